// ==== compile.f ====
+incdir+logic
logic/axi_mem_pkg.sv
logic/axi_mem_array.sv
logic/axi_write_ctrl.sv
logic/axi_read_ctrl.sv
logic/axi_mem_slave.sv
dv/axi_mem_asserts.sv
dv/axi_mem_tb.sv

// ==== Makefile ====
TOP = axi_mem_tb
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -Wno-fatal -f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TEST PASS" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// ==== dv/axi_mem_tb.sv ====
`timescale 1ns/1ns
`include "axi_mem_macros.svh"

module axi_mem_tb;

  localparam int          N_TXN  = 200;
  localparam int          PERIOD = 8;
  localparam logic [31:0] SEED   = 32'h5051;

  logic        clk, resetn;
  logic        awvalid, wvalid, wlast, bready, arvalid, rready;
  logic        awready, wready, bvalid, arready, rvalid, rlast;
  logic [3:0]  awid, awlen, arid, arlen, bid, rid, wstrb;
  logic [31:0] awaddr, araddr, wdata, rdata;
  logic [2:0]  awsize, arsize;
  logic [1:0]  awburst, arburst, bresp, rresp;
  logic [31:0] lfsr;
  logic [7:0]  model [`AXI_MEM_BYTES];   // reference byte memory

  axi_mem_slave u_dut (.*);

  bind axi_mem_slave axi_mem_asserts u_asserts (.*);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(N_TXN * 40 * PERIOD);
    $display("watchdog expired before the transactions finished");
    $display("TEST FAIL");
    $fatal(1, "timeout");
  end

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////
  task automatic check(input logic ok, input string msg);
    assert (ok) else begin
      $display("FAILED at %0t ns: %s", $time, msg);
      $display("TEST FAIL");
      $fatal(1, "check failed");
    end
  endtask

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};  // taps 32,22,2,1
      r    = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic logic [1:0] predict_resp(input logic [31:0] addr, input logic [3:0] len,
                                              input logic [2:0] size, input logic [1:0] burst);
    logic [32:0] last;
    last = {1'b0, addr};
    if (burst == `AXI_BURST_INCR) last = last + ({29'd0, len} << size);
    if (size > 2 || burst > `AXI_BURST_INCR) return `AXI_RESP_SLVERR;
    if (last >= `AXI_MEM_BYTES) return `AXI_RESP_DECERR;
    return `AXI_RESP_OKAY;
  endfunction

  task automatic write_burst(input logic [3:0] id, input logic [31:0] addr,
                             input logic [3:0] len, input logic [2:0] size,
                             input logic [1:0] burst);
    logic [1:0]  resp;
    logic [31:0] a;
    logic        done;
    resp = predict_resp(addr, len, size, burst);
    a    = addr;
    {awvalid, awid, awaddr, awlen, awsize, awburst} = {1'b1, id, addr, len, size, burst};
    @(negedge clk);
    while (!awready) @(negedge clk);
    @(posedge clk);
    #1 awvalid = 1'b0;
    for (int i = 0; i <= len; i++) begin
      repeat (rand_bits(1)) begin     // idle cycle on w
        @(posedge clk);
        #1;
      end
      wvalid = 1'b1;
      wdata  = rand_bits(32);
      wstrb  = rand_bits(4);
      wlast  = (i == len);
      @(negedge clk);
      while (!wready) @(negedge clk);
      @(posedge clk);
      #1 wvalid = 1'b0;
      if (resp == `AXI_RESP_OKAY) begin
        for (int b = 0; b < 4; b++) begin
          if (wstrb[b]) model[{a[6:2], 2'b00} + b] = wdata[b*8 +: 8];
        end
      end
      if (burst == `AXI_BURST_INCR) a = a + (32'd1 << size);
    end
    do begin
      bready = rand_bits(1);
      @(negedge clk);
      done = bvalid && bready;
      if (done) begin
        check(bid == id, $sformatf("bid %0h, expected %0h", bid, id));
        check(bresp == resp, $sformatf("bresp %0d, expected %0d", bresp, resp));
      end
      @(posedge clk);
      #1;
    end while (!done);
    bready = 1'b0;
    @(negedge clk);
    check(!bvalid && awready, "write channel did not return to idle after one b response");
    @(posedge clk);
    #1;
  endtask

  task automatic read_burst(input logic [3:0] id, input logic [31:0] addr,
                            input logic [3:0] len, input logic [2:0] size,
                            input logic [1:0] burst);
    logic [1:0]  resp;
    logic [31:0] a;
    logic [31:0] exp;
    int          beat;
    resp = predict_resp(addr, len, size, burst);
    a    = addr;
    beat = 0;
    {arvalid, arid, araddr, arlen, arsize, arburst} = {1'b1, id, addr, len, size, burst};
    @(negedge clk);
    while (!arready) @(negedge clk);
    @(posedge clk);
    #1 arvalid = 1'b0;
    while (beat <= len) begin
      rready = rand_bits(1);
      @(negedge clk);
      if (rvalid && rready) begin
        exp = '0;                       // error beats carry zero
        if (resp == `AXI_RESP_OKAY) begin
          exp = {model[{a[6:2], 2'b11}], model[{a[6:2], 2'b10}],
                 model[{a[6:2], 2'b01}], model[{a[6:2], 2'b00}]};
        end
        check(rid == id, $sformatf("rid %0h, expected %0h", rid, id));
        check(rresp == resp, $sformatf("rresp %0d, expected %0d", rresp, resp));
        check(rdata == exp, $sformatf("rdata %h, expected %h at %h", rdata, exp, a));
        check(rlast == (beat == len), $sformatf("rlast %0b on beat %0d", rlast, beat));
        if (burst == `AXI_BURST_INCR) a = a + (32'd1 << size);
        beat++;
      end
      @(posedge clk);
      #1;
    end
    rready = 1'b0;
    @(negedge clk);
    check(!rvalid && arready, "read channel sent more beats than arlen+1");
    @(posedge clk);
    #1;
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////
  initial begin
    logic [3:0]  id;
    logic [31:0] addr;
    logic [3:0]  len;
    logic [2:0]  size;
    logic [1:0]  burst;
    logic [2:0]  mode;
    lfsr = SEED;
    {awvalid, wvalid, wlast, bready, arvalid, rready} = '0;
    {awid, awaddr, awlen, awsize, awburst} = '0;
    {arid, araddr, arlen, arsize, arburst} = '0;
    {wdata, wstrb} = '0;
    for (int i = 0; i < `AXI_MEM_BYTES; i++) model[i] = `AXI_MEM_INIT;
    resetn = 1'b0;
    repeat (16) @(posedge clk);
    #1 resetn = 1'b1;
    @(negedge clk);
    check(awready && arready && !bvalid && !rvalid, "handshake outputs wrong after reset");
    @(posedge clk);
    #1;
    for (int i = 0; i < 4; i++) begin  // untouched memory reads back the fill
      read_burst(rand_bits(4), rand_bits(7) & 32'h7C, 4'd0, 3'd2, `AXI_BURST_INCR);
    end
    for (int t = 0; t < N_TXN / 2; t++) begin
      mode  = rand_bits(3);
      id    = rand_bits(4);
      addr  = rand_bits(7);
      len   = rand_bits(3);
      size  = rand_bits(2) % 3;
      burst = (mode == 0) ? `AXI_BURST_FIXED : `AXI_BURST_INCR;
      if (mode == 1) begin             // slave error case
        if (rand_bits(1)) size = 3'd3 + rand_bits(2);
        else burst = 2'd2 + rand_bits(1);
      end
      write_burst(id, addr, len, size, burst);
      read_burst(id + 4'd1, addr, len, size, burst);
    end
    read_burst(4'd1, 32'd0, 4'd15, 3'd2, `AXI_BURST_INCR);
    read_burst(4'd2, 32'd64, 4'd15, 3'd2, `AXI_BURST_INCR);
    $display("TEST PASS");
    $finish;
  end

endmodule

// ==== dv/axi_mem_asserts.sv ====
`timescale 1ns/1ns

module axi_mem_asserts (
  input logic clk,
  input logic resetn,
  input logic awready,
  input logic bvalid,
  input logic bready,
  input logic rvalid,
  input logic rready,
  input logic rlast
);

  bvalid_held: assert property (@(posedge clk) disable iff (!resetn)
    bvalid && !bready |=> bvalid) else $error("bvalid dropped before bready");

  rvalid_held: assert property (@(posedge clk) disable iff (!resetn)
    rvalid && !rready |=> rvalid) else $error("rvalid dropped before rready");

  // one outstanding write, so no new aw while b is pending
  no_aw_during_b: assert property (@(posedge clk) disable iff (!resetn)
    !(awready && bvalid)) else $error("awready high while bvalid pending");

  rlast_with_rvalid: assert property (@(posedge clk) disable iff (!resetn)
    rlast |-> rvalid) else $error("rlast high without rvalid");

endmodule

// ==== logic/axi_mem_slave.sv ====
`timescale 1ns/1ns

module axi_mem_slave (
  input  logic                clk,
  input  logic                resetn,
  input  logic                awvalid,
  output logic                awready,
  input  axi_mem_pkg::id_t    awid,
  input  axi_mem_pkg::addr_t  awaddr,
  input  axi_mem_pkg::len_t   awlen,
  input  axi_mem_pkg::size_t  awsize,
  input  axi_mem_pkg::burst_t awburst,
  input  logic                wvalid,
  output logic                wready,
  input  axi_mem_pkg::data_t  wdata,
  input  axi_mem_pkg::strb_t  wstrb,
  input  logic                wlast,
  output logic                bvalid,
  input  logic                bready,
  output axi_mem_pkg::id_t    bid,
  output axi_mem_pkg::resp_t  bresp,
  input  logic                arvalid,
  output logic                arready,
  input  axi_mem_pkg::id_t    arid,
  input  axi_mem_pkg::addr_t  araddr,
  input  axi_mem_pkg::len_t   arlen,
  input  axi_mem_pkg::size_t  arsize,
  input  axi_mem_pkg::burst_t arburst,
  output logic                rvalid,
  input  logic                rready,
  output axi_mem_pkg::id_t    rid,
  output axi_mem_pkg::data_t  rdata,
  output axi_mem_pkg::resp_t  rresp,
  output logic                rlast
);

  logic                   mem_we;
  axi_mem_pkg::word_idx_t mem_waddr;
  axi_mem_pkg::data_t     mem_wdata;
  axi_mem_pkg::strb_t     mem_wstrb;
  axi_mem_pkg::word_idx_t mem_raddr;     // read side owns this port
  axi_mem_pkg::data_t     mem_rdata;

  //////////////////////////////////////////////////////////////////////
  // write path
  //////////////////////////////////////////////////////////////////////
  axi_write_ctrl u_write (
    .clk       (clk),       .resetn   (resetn),
    .awvalid   (awvalid),   .awready  (awready),
    .awid      (awid),      .awaddr   (awaddr),
    .awlen     (awlen),     .awsize   (awsize),
    .awburst   (awburst),
    .wvalid    (wvalid),    .wready   (wready),
    .wdata     (wdata),     .wstrb    (wstrb),
    .wlast     (wlast),
    .bvalid    (bvalid),    .bready   (bready),
    .bid       (bid),       .bresp    (bresp),
    .mem_we    (mem_we),    .mem_waddr(mem_waddr),
    .mem_wdata (mem_wdata), .mem_wstrb(mem_wstrb)
  );

  //////////////////////////////////////////////////////////////////////
  // read path
  //////////////////////////////////////////////////////////////////////
  axi_read_ctrl u_read (
    .clk      (clk),       .resetn   (resetn),
    .arvalid  (arvalid),   .arready  (arready),
    .arid     (arid),      .araddr   (araddr),
    .arlen    (arlen),     .arsize   (arsize),
    .arburst  (arburst),
    .rvalid   (rvalid),    .rready   (rready),
    .rid      (rid),       .rdata    (rdata),
    .rresp    (rresp),     .rlast    (rlast),
    .mem_raddr(mem_raddr), .mem_rdata(mem_rdata)
  );

  axi_mem_array u_mem (
    .clk   (clk),
    .resetn(resetn),
    .we    (mem_we),
    .waddr (mem_waddr),
    .wdata (mem_wdata),
    .wstrb (mem_wstrb),
    .raddr (mem_raddr),
    .rdata (mem_rdata)
  );

endmodule

// ==== logic/axi_read_ctrl.sv ====
`timescale 1ns/1ns
`include "axi_mem_macros.svh"

module axi_read_ctrl (
  input  logic                   clk,
  input  logic                   resetn,
  input  logic                   arvalid,
  output logic                   arready,
  input  axi_mem_pkg::id_t       arid,
  input  axi_mem_pkg::addr_t     araddr,
  input  axi_mem_pkg::len_t      arlen,
  input  axi_mem_pkg::size_t     arsize,
  input  axi_mem_pkg::burst_t    arburst,
  output logic                   rvalid,
  input  logic                   rready,
  output axi_mem_pkg::id_t       rid,
  output axi_mem_pkg::data_t     rdata,
  output axi_mem_pkg::resp_t     rresp,
  output logic                   rlast,
  output axi_mem_pkg::word_idx_t mem_raddr,
  input  axi_mem_pkg::data_t     mem_rdata
);

  axi_mem_pkg::rd_state_e state;
  axi_mem_pkg::id_t       id_q;
  axi_mem_pkg::len_t      len_q;
  axi_mem_pkg::len_t      cnt_q;           // beats sent so far
  axi_mem_pkg::size_t     size_q;
  axi_mem_pkg::burst_t    burst_q;
  axi_mem_pkg::addr_t     addr_q;
  axi_mem_pkg::resp_t     resp_q;
  axi_mem_pkg::resp_t     ar_resp;
  logic [`AXI_ADDR_W:0]   ar_span;
  logic [`AXI_ADDR_W:0]   ar_last_addr;
  logic                   ar_fire;
  logic                   r_fire;

  assign arready = (state == axi_mem_pkg::rd_addr);
  assign rvalid  = (state == axi_mem_pkg::rd_data);
  assign rid     = id_q;
  assign rresp   = resp_q;
  assign rlast   = rvalid && (cnt_q == len_q);

  assign ar_fire = arvalid && arready;
  assign r_fire  = rvalid && rready;

  //////////////////////////////////////////////////////////////////////
  // error check on the ar request, same rules as the write side
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    ar_span      = arlen;
    ar_span      = ar_span << arsize[1:0];
    ar_last_addr = {1'b0, araddr};
    if (arburst == `AXI_BURST_INCR) begin
      ar_last_addr = ar_last_addr + ar_span;
    end
    if (arsize > `AXI_MAX_SIZE ||
        (arburst != `AXI_BURST_FIXED && arburst != `AXI_BURST_INCR)) begin
      ar_resp = `AXI_RESP_SLVERR;
    end else if (ar_last_addr >= `AXI_MEM_BYTES) begin
      ar_resp = `AXI_RESP_DECERR;
    end else begin
      ar_resp = `AXI_RESP_OKAY;
    end
  end

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      state <= axi_mem_pkg::rd_addr;
    end else begin
      case (state)
        axi_mem_pkg::rd_addr: if (ar_fire) state <= axi_mem_pkg::rd_data;
        axi_mem_pkg::rd_data: if (r_fire && rlast) state <= axi_mem_pkg::rd_addr;
        default:              state <= axi_mem_pkg::rd_addr;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (ar_fire) begin
      id_q    <= arid;
      len_q   <= arlen;
      size_q  <= arsize;
      burst_q <= arburst;
      addr_q  <= araddr;
      resp_q  <= ar_resp;
      cnt_q   <= '0;
    end else if (r_fire) begin
      cnt_q <= cnt_q + 1'b1;
      if (burst_q == `AXI_BURST_INCR) begin
        addr_q <= addr_q + (axi_mem_pkg::addr_t'(1) << size_q[1:0]);
      end
    end
  end

  assign mem_raddr = axi_mem_pkg::word_idx_t'(addr_q >> 2);
  // zero data on error beats
  assign rdata     = (rvalid && resp_q == `AXI_RESP_OKAY) ? mem_rdata : '0;

endmodule

// ==== logic/axi_write_ctrl.sv ====
`timescale 1ns/1ns
`include "axi_mem_macros.svh"

module axi_write_ctrl (
  input  logic                   clk,
  input  logic                   resetn,
  input  logic                   awvalid,
  output logic                   awready,
  input  axi_mem_pkg::id_t       awid,
  input  axi_mem_pkg::addr_t     awaddr,
  input  axi_mem_pkg::len_t      awlen,
  input  axi_mem_pkg::size_t     awsize,
  input  axi_mem_pkg::burst_t    awburst,
  input  logic                   wvalid,
  output logic                   wready,
  input  axi_mem_pkg::data_t     wdata,
  input  axi_mem_pkg::strb_t     wstrb,
  input  logic                   wlast,
  output logic                   bvalid,
  input  logic                   bready,
  output axi_mem_pkg::id_t       bid,
  output axi_mem_pkg::resp_t     bresp,
  output logic                   mem_we,
  output axi_mem_pkg::word_idx_t mem_waddr,
  output axi_mem_pkg::data_t     mem_wdata,
  output axi_mem_pkg::strb_t     mem_wstrb
);

  axi_mem_pkg::wr_state_e state;
  axi_mem_pkg::id_t       id_q;
  axi_mem_pkg::len_t      len_q;
  axi_mem_pkg::len_t      cnt_q;           // beats taken so far
  axi_mem_pkg::size_t     size_q;
  axi_mem_pkg::burst_t    burst_q;
  axi_mem_pkg::addr_t     addr_q;          // current beat address
  axi_mem_pkg::resp_t     resp_q;
  axi_mem_pkg::resp_t     aw_resp;
  logic [`AXI_ADDR_W:0]   aw_span;
  logic [`AXI_ADDR_W:0]   aw_last_addr;    // extra bit catches carry out
  logic                   aw_fire;
  logic                   w_fire;
  logic                   w_done;

  assign awready = (state == axi_mem_pkg::wr_addr);
  assign wready  = (state == axi_mem_pkg::wr_data);
  assign bvalid  = (state == axi_mem_pkg::wr_resp);
  assign bid     = id_q;
  assign bresp   = resp_q;

  assign aw_fire = awvalid && awready;
  assign w_fire  = wvalid && wready;
  assign w_done  = wlast || (cnt_q == len_q);   // whichever comes first ends the burst

  //////////////////////////////////////////////////////////////////////
  // response decided once, at the aw transfer
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    aw_span      = awlen;
    aw_span      = aw_span << awsize[1:0];
    aw_last_addr = {1'b0, awaddr};
    if (awburst == `AXI_BURST_INCR) begin
      aw_last_addr = aw_last_addr + aw_span;
    end
    if (awsize > `AXI_MAX_SIZE ||
        (awburst != `AXI_BURST_FIXED && awburst != `AXI_BURST_INCR)) begin
      aw_resp = `AXI_RESP_SLVERR;
    end else if (aw_last_addr >= `AXI_MEM_BYTES) begin
      aw_resp = `AXI_RESP_DECERR;
    end else begin
      aw_resp = `AXI_RESP_OKAY;
    end
  end

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      state <= axi_mem_pkg::wr_addr;
    end else begin
      case (state)
        axi_mem_pkg::wr_addr: if (aw_fire) state <= axi_mem_pkg::wr_data;
        axi_mem_pkg::wr_data: if (w_fire && w_done) state <= axi_mem_pkg::wr_resp;
        axi_mem_pkg::wr_resp: if (bready) state <= axi_mem_pkg::wr_addr;
        default:              state <= axi_mem_pkg::wr_addr;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (aw_fire) begin
      id_q    <= awid;
      len_q   <= awlen;
      size_q  <= awsize;
      burst_q <= awburst;
      addr_q  <= awaddr;
      resp_q  <= aw_resp;
      cnt_q   <= '0;
    end else if (w_fire) begin
      cnt_q <= cnt_q + 1'b1;
      if (burst_q == `AXI_BURST_INCR) begin
        addr_q <= addr_q + (axi_mem_pkg::addr_t'(1) << size_q[1:0]);  // FIXED stays put
      end
    end
  end

  assign mem_we    = w_fire && (resp_q == `AXI_RESP_OKAY);   // erroring beats are dropped
  assign mem_waddr = axi_mem_pkg::word_idx_t'(addr_q >> 2);
  assign mem_wdata = wdata;
  assign mem_wstrb = wstrb;

endmodule

// ==== logic/axi_mem_array.sv ====
`timescale 1ns/1ns
`include "axi_mem_macros.svh"

module axi_mem_array (
  input  logic                  clk,
  input  logic                  resetn,
  input  logic                  we,
  input  axi_mem_pkg::word_idx_t waddr,
  input  axi_mem_pkg::data_t    wdata,
  input  axi_mem_pkg::strb_t    wstrb,
  input  axi_mem_pkg::word_idx_t raddr,
  output axi_mem_pkg::data_t    rdata
);

  logic [7:0] mem [`AXI_MEM_WORDS][`AXI_STRB_W];   // word x byte lane

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      for (int w = 0; w < `AXI_MEM_WORDS; w++) begin
        for (int b = 0; b < `AXI_STRB_W; b++) begin
          mem[w][b] <= `AXI_MEM_INIT;
        end
      end
    end else if (we) begin
      for (int b = 0; b < `AXI_STRB_W; b++) begin
        if (wstrb[b]) begin
          mem[waddr][b] <= wdata[b*8 +: 8];           // only strobed lanes change
        end
      end
    end
  end

  always_comb begin
    for (int b = 0; b < `AXI_STRB_W; b++) begin
      rdata[b*8 +: 8] = mem[raddr][b];
    end
  end

endmodule

// ==== logic/axi_mem_pkg.sv ====
`include "axi_mem_macros.svh"

package axi_mem_pkg;

  typedef logic [`AXI_ADDR_W-1:0] addr_t;        // byte address
  typedef logic [`AXI_DATA_W-1:0] data_t;
  typedef logic [`AXI_STRB_W-1:0] strb_t;
  typedef logic [`AXI_ID_W-1:0]   id_t;
  typedef logic [`AXI_LEN_W-1:0]  len_t;         // beats minus one
  typedef logic [2:0]             size_t;
  typedef logic [1:0]             burst_t;
  typedef logic [1:0]             resp_t;
  typedef logic [$clog2(`AXI_MEM_WORDS)-1:0] word_idx_t;

  typedef enum logic [1:0] {
    wr_addr,                                      // waiting for aw
    wr_data,                                      // taking w beats
    wr_resp                                       // holding b
  } wr_state_e;

  typedef enum logic {
    rd_addr,
    rd_data
  } rd_state_e;

endpackage

// ==== logic/axi_mem_macros.svh ====
`ifndef AXI_MEM_MACROS_SVH
`define AXI_MEM_MACROS_SVH

`define AXI_ADDR_W      32
`define AXI_DATA_W      32
`define AXI_STRB_W      4
`define AXI_ID_W        4
`define AXI_LEN_W       4

`define AXI_MEM_BYTES   128     // flop memory size
`define AXI_MEM_WORDS   32
`define AXI_MAX_SIZE    2       // 4-byte beats at most
`define AXI_MEM_INIT    8'h0C   // fill byte after reset

`define AXI_BURST_FIXED 2'd0
`define AXI_BURST_INCR  2'd1

`define AXI_RESP_OKAY   2'd0
`define AXI_RESP_SLVERR 2'd2
`define AXI_RESP_DECERR 2'd3

`endif
